// ==== source/core_pkg.sv ====
/*
  Data, opcode and hart ID types shared by the cores and the top level.
  All operations wrap at DataWidth bits. OP_MUL keeps only the low word.
*/
`default_nettype none

package core_pkg;

  localparam int unsigned DataWidth   = 32;
  localparam int unsigned HartIdWidth = 8;
  localparam int unsigned ShamtWidth  = $clog2(DataWidth); // Shift range of OP_SHL

  typedef logic [DataWidth-1:0]   data_t;    // Accumulator and operand value
  typedef logic [HartIdWidth-1:0] hart_id_t; // Core identity carried with results
  typedef logic [ShamtWidth-1:0]  shamt_t;   // Low operand bits used as shift amount

  // Accumulator operations, acc is the running value of one core
  typedef enum logic [2:0] {
    OP_LOAD = 3'd0, // acc = operand
    OP_ADD  = 3'd1, // acc + operand
    OP_SUB  = 3'd2, // acc - operand
    OP_XOR  = 3'd3,
    OP_AND  = 3'd4,
    OP_OR   = 3'd5,
    OP_SHL  = 3'd6, // acc << operand[4:0]
    OP_MUL  = 3'd7  // Low 32 bits of the product
  } opcode_e;

endpackage : core_pkg

`default_nettype wire

// ==== source/hmr_pkg.sv ====
/*
  Redundancy modes and pairing helpers.
  A DMR group is PairSize consecutive cores, led by the lowest (even) index.
*/
`default_nettype none

package hmr_pkg;

  typedef enum logic {
    MODE_INDEP = 1'b0, // Each core on its own lane
    MODE_DMR   = 1'b1  // Cores run in lockstep pairs
  } hmr_mode_e;

  localparam int unsigned PairSize = 2; // Cores per DMR group

  // Core that leads the group of core_idx
  function automatic int unsigned pair_lead(input int unsigned core_idx);
    return core_idx - (core_idx % PairSize);
  endfunction

  function automatic int unsigned pair_idx(input int unsigned core_idx);
    return core_idx / PairSize; // Group number
  endfunction

endpackage : hmr_pkg

`default_nettype wire

// ==== source/hmr_input_bind.sv ====
/*
  Lane to core routing, purely combinational.
  In DMR both cores of a pair take the lead lane, while the fault bit stays per core.
  The mode may only change while every lane is idle.
*/
`default_nettype none

module hmr_input_bind #(
  parameter int unsigned NumCores = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  hmr_pkg::hmr_mode_e                   mode_i,
  input  core_pkg::hart_id_t                   hart_base_i,
  input  logic               [NumCores-1:0]    lane_valid_i,
  input  core_pkg::opcode_e  [NumCores-1:0]    lane_opcode_i,
  input  core_pkg::data_t    [NumCores-1:0]    lane_operand_i,
  input  logic               [NumCores-1:0]    lane_fault_i,
  output logic               [NumCores-1:0]    core_valid_o,
  output core_pkg::opcode_e  [NumCores-1:0]    core_opcode_o,
  output core_pkg::data_t    [NumCores-1:0]    core_operand_o,
  output logic               [NumCores-1:0]    core_fault_o,
  output core_pkg::hart_id_t [NumCores-1:0]    core_hart_id_o
);

  import core_pkg::*;
  import hmr_pkg::*;

  logic dmr_sel;

  assign dmr_sel = (mode_i == MODE_DMR);

  for (genvar i = 0; i < NumCores; i++) begin : gen_bind
    localparam int unsigned Lead = pair_lead(i); // Lane feeding this core in DMR

    assign core_valid_o[i]   = dmr_sel ? lane_valid_i[Lead]   : lane_valid_i[i];
    assign core_opcode_o[i]  = dmr_sel ? lane_opcode_i[Lead]  : lane_opcode_i[i];
    assign core_operand_o[i] = dmr_sel ? lane_operand_i[Lead] : lane_operand_i[i];
    assign core_fault_o[i]   = lane_fault_i[i];              // Injection stays per core
    assign core_hart_id_o[i] = hart_base_i + hart_id_t'(i);  // Base ID plus core index
  end

  // Pairing must not move under an operation that is being issued
  a_mode_stable_when_busy: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (|lane_valid_i) |-> $stable(mode_i)
  ) else $error("redundancy mode changed while a lane was active");

endmodule : hmr_input_bind

`default_nettype wire

// ==== source/acc_core.sv ====
/*
  Two-stage accumulator core with a checkpoint restore port.
  The fault input flips bit 0 of the reported result only, the accumulator is untouched.
  A restore must not coincide with a new operation.
*/
`default_nettype none

module acc_core (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  core_pkg::opcode_e  opcode_i,
  input  core_pkg::data_t    operand_i,
  input  logic               fault_i,
  input  core_pkg::hart_id_t hart_id_i,
  input  logic               restore_i,
  input  core_pkg::data_t    restore_value_i,
  output logic               res_valid_o,
  output core_pkg::data_t    res_data_o,
  output core_pkg::hart_id_t res_hart_id_o
);

  import core_pkg::*;

  logic     s1_valid_q;
  opcode_e  s1_opcode_q;
  data_t    s1_operand_q;
  logic     s1_fault_q;
  hart_id_t s1_hart_id_q;

  data_t    acc_q;
  data_t    acc_d;
  shamt_t   shamt;

  logic     res_valid_q;
  data_t    res_data_q;
  hart_id_t res_hart_id_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= valid_i; // Stage 1 occupancy
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      s1_opcode_q  <= opcode_i;
      s1_operand_q <= operand_i;
      s1_fault_q   <= fault_i;
      s1_hart_id_q <= hart_id_i;
    end
  end

  assign shamt = s1_operand_q[ShamtWidth-1:0];

  // Next accumulator value
  always_comb begin
    case (s1_opcode_q)
      OP_LOAD: acc_d = s1_operand_q;
      OP_ADD:  acc_d = acc_q + s1_operand_q;
      OP_SUB:  acc_d = acc_q - s1_operand_q;
      OP_XOR:  acc_d = acc_q ^ s1_operand_q;
      OP_AND:  acc_d = acc_q & s1_operand_q;
      OP_OR:   acc_d = acc_q | s1_operand_q;
      OP_SHL:  acc_d = acc_q << shamt;
      OP_MUL:  acc_d = acc_q * s1_operand_q; // Truncated to the low word
      default: acc_d = acc_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
    end else if (restore_i) begin
      acc_q <= restore_value_i; // Rapid recovery from the pair checkpoint
    end else if (s1_valid_q) begin
      acc_q <= acc_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid_q) begin
      res_data_q    <= acc_d ^ data_t'(s1_fault_q); // Injected fault hits bit 0
      res_hart_id_q <= s1_hart_id_q;
    end
  end

  assign res_valid_o   = res_valid_q;
  assign res_data_o    = res_data_q;
  assign res_hart_id_o = res_hart_id_q;

  // Voter restore and a fresh operation from the binding never overlap
  a_no_restore_with_op: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(restore_i && valid_i)
  ) else $error("restore collided with a new operation");

endmodule : acc_core

`default_nettype wire

// ==== source/hmr_result_vote.sv ====
/*
  Result stage. Registers core results onto the output lanes.
  In DMR each pair is compared, only the even lane reports, and agreed values become
  the checkpoint. A mismatch drops the result, pulses dmr_error and restores both cores.
  Operations in flight during a recovery are not replayed.
*/
`default_nettype none

module hmr_result_vote #(
  parameter int unsigned NumCores = 4
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  hmr_pkg::hmr_mode_e                            mode_i,
  input  logic               [NumCores-1:0]             core_valid_i,
  input  core_pkg::data_t    [NumCores-1:0]             core_data_i,
  input  core_pkg::hart_id_t [NumCores-1:0]             core_hart_id_i,
  output logic               [NumCores-1:0]             restore_o,
  output core_pkg::data_t    [NumCores-1:0]             restore_value_o,
  output logic               [NumCores-1:0]             out_valid_o,
  output core_pkg::data_t    [NumCores-1:0]             out_data_o,
  output core_pkg::hart_id_t [NumCores-1:0]             out_hart_id_o,
  output logic               [NumCores/hmr_pkg::PairSize-1:0] dmr_error_o
);

  import core_pkg::*;
  import hmr_pkg::*;

  localparam int unsigned NumPairs = NumCores / PairSize;

  logic                     dmr_sel;
  logic     [NumPairs-1:0]  pair_fire;
  logic     [NumPairs-1:0]  pair_match;
  logic     [NumPairs-1:0]  pair_agree;
  logic     [NumPairs-1:0]  pair_error;
  logic     [NumCores-1:0]  out_valid_d;

  logic     [NumCores-1:0]  out_valid_q;
  data_t    [NumCores-1:0]  out_data_q;
  hart_id_t [NumCores-1:0]  out_hart_id_q;
  logic     [NumPairs-1:0]  recover_q;  // Drives both the error pulse and the restore
  data_t    [NumPairs-1:0]  ckpt_q;     // Last agreed value per pair

  assign dmr_sel = (mode_i == MODE_DMR);

  for (genvar p = 0; p < NumPairs; p++) begin : gen_pair
    localparam int unsigned Lead = p * PairSize;

    assign pair_fire[p]  = dmr_sel && core_valid_i[Lead];
    assign pair_match[p] = (core_data_i[Lead] == core_data_i[Lead+1]);
    assign pair_agree[p] = pair_fire[p] && pair_match[p];
    assign pair_error[p] = pair_fire[p] && !pair_match[p];

    // Lockstep cores must deliver results in the same cycle
    a_pair_lockstep: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (mode_i == MODE_DMR) |-> (core_valid_i[Lead] == core_valid_i[Lead+1])
    ) else $error("DMR pair %0d lost lockstep", p);
  end

  for (genvar i = 0; i < NumCores; i++) begin : gen_lane
    localparam bit IsLead = (pair_lead(i) == i);

    // Only the lead lane reports in DMR, and only on agreement
    assign out_valid_d[i]     = dmr_sel ? (IsLead && pair_agree[pair_idx(i)])
                                        : core_valid_i[i];
    assign restore_o[i]       = recover_q[pair_idx(i)];
    assign restore_value_o[i] = ckpt_q[pair_idx(i)];
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= '0;
      recover_q   <= '0;
      ckpt_q      <= '0;
    end else begin
      out_valid_q <= out_valid_d;
      recover_q   <= pair_error; // One cycle pulse per mismatch
      for (int unsigned p = 0; p < NumPairs; p++) begin
        if (pair_agree[p]) begin
          ckpt_q[p] <= core_data_i[p*PairSize];
        end
      end
    end
  end

  // Lead data equals the lane's own data in both modes
  always_ff @(posedge clk_i) begin
    for (int unsigned i = 0; i < NumCores; i++) begin
      if (core_valid_i[i]) begin
        out_data_q[i]    <= core_data_i[i];
        out_hart_id_q[i] <= core_hart_id_i[i];
      end
    end
  end

  assign out_valid_o   = out_valid_q;
  assign out_data_o    = out_data_q;
  assign out_hart_id_o = out_hart_id_q;
  assign dmr_error_o   = recover_q;

endmodule : hmr_result_vote

`default_nettype wire

// ==== source/hmr_acc_top.sv ====
/*
  Redundant accumulator subsystem. Fixed 3 cycle latency from lane strobe to output.
  NumCores must be even. There is no back-pressure.
  Change dmr_mode_i only while all lanes are idle. After a faulty DMR operation
  keep that pair idle for at least 4 cycles.
*/
`default_nettype none

module hmr_acc_top #(
  parameter int unsigned NumCores = 4
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                                          dmr_mode_i,
  input  core_pkg::hart_id_t                            hart_base_i,
  input  logic               [NumCores-1:0]             lane_valid_i,
  input  core_pkg::opcode_e  [NumCores-1:0]             lane_opcode_i,
  input  core_pkg::data_t    [NumCores-1:0]             lane_operand_i,
  input  logic               [NumCores-1:0]             lane_fault_i,
  output logic               [NumCores-1:0]             out_valid_o,
  output core_pkg::data_t    [NumCores-1:0]             out_data_o,
  output core_pkg::hart_id_t [NumCores-1:0]             out_hart_id_o,
  output logic               [NumCores/hmr_pkg::PairSize-1:0] dmr_error_o
);

  import core_pkg::*;
  import hmr_pkg::*;

  hmr_mode_e                mode;
  logic     [NumCores-1:0]  bind_valid;
  opcode_e  [NumCores-1:0]  bind_opcode;
  data_t    [NumCores-1:0]  bind_operand;
  logic     [NumCores-1:0]  bind_fault;
  hart_id_t [NumCores-1:0]  bind_hart_id;
  logic     [NumCores-1:0]  res_valid;
  data_t    [NumCores-1:0]  res_data;
  hart_id_t [NumCores-1:0]  res_hart_id;
  logic     [NumCores-1:0]  restore;
  data_t    [NumCores-1:0]  restore_value;

  assign mode = hmr_mode_e'(dmr_mode_i);

  if ((NumCores < PairSize) || ((NumCores % PairSize) != 0)) begin : gen_cfg_check
    $error("NumCores must be a nonzero multiple of PairSize");
  end

  hmr_input_bind #(
    .NumCores ( NumCores )
  ) i_input_bind (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .mode_i         ( mode           ),
    .hart_base_i    ( hart_base_i    ),
    .lane_valid_i   ( lane_valid_i   ),
    .lane_opcode_i  ( lane_opcode_i  ),
    .lane_operand_i ( lane_operand_i ),
    .lane_fault_i   ( lane_fault_i   ),
    .core_valid_o   ( bind_valid     ),
    .core_opcode_o  ( bind_opcode    ),
    .core_operand_o ( bind_operand   ),
    .core_fault_o   ( bind_fault     ),
    .core_hart_id_o ( bind_hart_id   )
  );

  for (genvar i = 0; i < NumCores; i++) begin : gen_cores
    acc_core i_acc_core (
      .clk_i           ( clk_i            ),
      .rst_n_i         ( rst_n_i          ),
      .valid_i         ( bind_valid[i]    ),
      .opcode_i        ( bind_opcode[i]   ),
      .operand_i       ( bind_operand[i]  ),
      .fault_i         ( bind_fault[i]    ),
      .hart_id_i       ( bind_hart_id[i]  ),
      .restore_i       ( restore[i]       ),
      .restore_value_i ( restore_value[i] ),
      .res_valid_o     ( res_valid[i]     ),
      .res_data_o      ( res_data[i]      ),
      .res_hart_id_o   ( res_hart_id[i]   )
    );
  end

  hmr_result_vote #(
    .NumCores ( NumCores )
  ) i_result_vote (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .mode_i          ( mode          ),
    .core_valid_i    ( res_valid     ),
    .core_data_i     ( res_data      ),
    .core_hart_id_i  ( res_hart_id   ),
    .restore_o       ( restore       ),
    .restore_value_o ( restore_value ),
    .out_valid_o     ( out_valid_o   ),
    .out_data_o      ( out_data_o    ),
    .out_hart_id_o   ( out_hart_id_o ),
    .dmr_error_o     ( dmr_error_o   )
  );

endmodule : hmr_acc_top

`default_nettype wire

// ==== verif/tb_hmr_acc_top.sv ====
/*
  Random-stimulus testbench for hmr_acc_top with NumCores = 4.
  A reference model predicts every lane 3 cycles after its strobe.
  DMR mismatches hold the pair idle for 4 cycles, and mode changes only after a drain.
*/
`default_nettype none

module tb_hmr_acc_top;

  import core_pkg::*;
  import hmr_pkg::*;

  localparam int unsigned NumCores    = 4;
  localparam int unsigned NumPairs    = NumCores / PairSize;
  localparam int unsigned ClkHalf     = 4;
  localparam int unsigned ResetCycles = 3;
  localparam int unsigned Seed        = 30549;
  localparam int unsigned Latency     = 3;  // Strobe to output valid
  localparam int unsigned HoldCycles  = 4;  // Idle cycles after a DMR mismatch
  localparam int unsigned OpsPerPhase = 40;
  localparam int unsigned NumPhases   = 6;
  localparam int unsigned TotalOps    = OpsPerPhase * NumPhases;
  localparam int unsigned CycleLimit  = TotalOps * 6 + 100;

  logic                          clk = 1'b0;
  logic                          rst_n;
  logic                          dmr_mode;
  hart_id_t                      hart_base;
  logic     [NumCores-1:0]       lane_valid;
  opcode_e  [NumCores-1:0]       lane_opcode;
  data_t    [NumCores-1:0]       lane_operand;
  logic     [NumCores-1:0]       lane_fault;
  logic     [NumCores-1:0]       out_valid;
  data_t    [NumCores-1:0]       out_data;
  hart_id_t [NumCores-1:0]       out_hart_id;
  logic     [NumPairs-1:0]       dmr_error;

  data_t       model_acc [NumCores];
  data_t       model_ckpt [NumPairs];   // Last agreed value per pair
  int unsigned pair_hold [NumPairs];
  hmr_mode_e   cur_mode;
  hart_id_t    cur_base;

  logic     [NumCores-1:0] exp_valid_q[$];
  data_t    [NumCores-1:0] exp_data_q[$];
  hart_id_t [NumCores-1:0] exp_hart_q[$];
  logic     [NumPairs-1:0] exp_err_q[$];

  int unsigned n_checks   = 0;
  int unsigned valid_errs = 0;
  int unsigned data_errs  = 0;
  int unsigned hart_errs  = 0;
  int unsigned pulse_errs = 0;
  int unsigned cycle_cnt  = 0;

  hmr_acc_top #(
    .NumCores ( NumCores )
  ) hmr_acc_top_inst (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .dmr_mode_i     ( dmr_mode     ),
    .hart_base_i    ( hart_base    ),
    .lane_valid_i   ( lane_valid   ),
    .lane_opcode_i  ( lane_opcode  ),
    .lane_operand_i ( lane_operand ),
    .lane_fault_i   ( lane_fault   ),
    .out_valid_o    ( out_valid    ),
    .out_data_o     ( out_data     ),
    .out_hart_id_o  ( out_hart_id  ),
    .dmr_error_o    ( dmr_error    )
  );

  always #ClkHalf clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CycleLimit) begin
      $display("Timeout: run still going after %0d cycles", CycleLimit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // Accumulator rules on a 32-bit word with wraparound
  function automatic data_t next_acc(input data_t acc, input opcode_e op, input data_t opd);
    logic [63:0] prod;
    prod = {32'd0, acc} * {32'd0, opd};
    case (op)
      OP_LOAD: return opd;
      OP_ADD:  return acc + opd;
      OP_SUB:  return acc - opd;
      OP_XOR:  return acc ^ opd;
      OP_AND:  return acc & opd;
      OP_OR:   return acc | opd;
      OP_SHL:  return acc << opd[4:0];
      OP_MUL:  return prod[31:0];  // Low word only
      default: return acc;
    endcase
  endfunction

  task automatic check_valid(input int unsigned lane, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      valid_errs++;
      $display("[ERROR] %0t: lane %0d valid %b, expected %b", $time, lane, got, exp);
    end
  endtask

  task automatic check_data(input int unsigned lane, input data_t got, input data_t exp);
    n_checks++;
    if (got !== exp) begin
      data_errs++;
      $display("[ERROR] %0t: lane %0d data 0x%08h, expected 0x%08h", $time, lane, got, exp);
    end
  endtask

  task automatic check_hart(input int unsigned lane, input hart_id_t got, input hart_id_t exp);
    n_checks++;
    if (got !== exp) begin
      hart_errs++;
      $display("[ERROR] %0t: lane %0d hart ID 0x%02h, expected 0x%02h", $time, lane, got, exp);
    end
  endtask

  task automatic check_error(input int unsigned pair, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      pulse_errs++;
      $display("[ERROR] %0t: pair %0d dmr_error %b, expected %b", $time, pair, got, exp);
    end
  endtask

  task automatic push_expect(input logic [NumCores-1:0] ev, input data_t [NumCores-1:0] ed,
                             input hart_id_t [NumCores-1:0] eh, input logic [NumPairs-1:0] ee);
    exp_valid_q.push_back(ev);
    exp_data_q.push_back(ed);
    exp_hart_q.push_back(eh);
    exp_err_q.push_back(ee);
  endtask

  task automatic compare_oldest();
    logic     [NumCores-1:0] ev;
    data_t    [NumCores-1:0] ed;
    hart_id_t [NumCores-1:0] eh;
    logic     [NumPairs-1:0] ee;
    ev = exp_valid_q.pop_front();
    ed = exp_data_q.pop_front();
    eh = exp_hart_q.pop_front();
    ee = exp_err_q.pop_front();
    for (int unsigned i = 0; i < NumCores; i++) begin
      check_valid(i, out_valid[i], ev[i]);
      if (ev[i]) begin
        check_data(i, out_data[i], ed[i]);
        check_hart(i, out_hart_id[i], eh[i]);
      end
    end
    for (int unsigned p = 0; p < NumPairs; p++) begin
      check_error(p, dmr_error[p], ee[p]);
    end
  endtask

  // Drive one cycle at the rising edge, check outputs of the op from 3 cycles back
  task automatic run_cycle(input logic [NumCores-1:0] v, input opcode_e [NumCores-1:0] op,
                           input data_t [NumCores-1:0] opd, input logic [NumCores-1:0] f,
                           input logic [NumCores-1:0] ev, input data_t [NumCores-1:0] ed,
                           input hart_id_t [NumCores-1:0] eh, input logic [NumPairs-1:0] ee);
    @(posedge clk);
    dmr_mode     <= (cur_mode == MODE_DMR);
    hart_base    <= cur_base;
    lane_valid   <= v;
    lane_opcode  <= op;
    lane_operand <= opd;
    lane_fault   <= f;
    push_expect(ev, ed, eh, ee);
    @(negedge clk);
    compare_oldest();
  endtask

  task automatic idle_cycles(input int unsigned n);
    opcode_e [NumCores-1:0] zop;
    for (int unsigned i = 0; i < NumCores; i++) begin
      zop[i] = OP_LOAD;
    end
    repeat (n) begin
      for (int unsigned p = 0; p < NumPairs; p++) begin
        if (pair_hold[p] != 0) pair_hold[p]--;
      end
      run_cycle('0, zop, '0, '0, '0, '0, '0, '0);
    end
  endtask

  task automatic issue_indep(input bit with_faults);
    logic     [NumCores-1:0] v;
    opcode_e  [NumCores-1:0] op;
    data_t    [NumCores-1:0] opd;
    logic     [NumCores-1:0] f;
    logic     [NumCores-1:0] ev;
    data_t    [NumCores-1:0] ed;
    hart_id_t [NumCores-1:0] eh;
    logic     [2:0]          r3;
    ev = '0;
    ed = '0;
    eh = '0;
    for (int unsigned i = 0; i < NumCores; i++) begin
      v[i]   = ($urandom_range(0, 3) != 0);
      r3     = 3'($urandom_range(0, 7));
      op[i]  = opcode_e'(r3);
      opd[i] = $urandom();
      f[i]   = v[i] && with_faults && ($urandom_range(0, 5) == 0);
      if (v[i]) begin
        model_acc[i] = next_acc(model_acc[i], op[i], opd[i]);
        ev[i]        = 1'b1;
        ed[i]        = model_acc[i];
        ed[i][0]     = model_acc[i][0] ^ f[i];  // Fault shows in the result only
        eh[i]        = cur_base + hart_id_t'(i);
      end
    end
    run_cycle(v, op, opd, f, ev, ed, eh, '0);
  endtask

  task automatic issue_dmr(input bit with_faults);
    logic     [NumCores-1:0] v;
    opcode_e  [NumCores-1:0] op;
    data_t    [NumCores-1:0] opd;
    logic     [NumCores-1:0] f;
    logic     [NumCores-1:0] ev;
    data_t    [NumCores-1:0] ed;
    hart_id_t [NumCores-1:0] eh;
    logic     [NumPairs-1:0] ee;
    logic     [2:0]          r3;
    int unsigned             lead;
    data_t                   n0;
    data_t                   n1;
    data_t                   r0;
    data_t                   r1;
    v  = '0;
    f  = '0;
    ev = '0;
    ed = '0;
    eh = '0;
    ee = '0;
    for (int unsigned i = 0; i < NumCores; i++) begin
      r3     = 3'($urandom_range(0, 7));
      op[i]  = opcode_e'(r3);  // Odd lanes carry junk the binding ignores
      opd[i] = $urandom();
    end
    for (int unsigned p = 0; p < NumPairs; p++) begin
      lead = p * PairSize;
      if (pair_hold[p] != 0) begin
        pair_hold[p]--;
      end else if ($urandom_range(0, 3) != 0) begin
        v[lead] = 1'b1;
        if (with_faults && ($urandom_range(0, 3) == 0)) begin
          f[lead + $urandom_range(0, 1)] = 1'b1;  // One core of the pair only
        end
        n0    = next_acc(model_acc[lead], op[lead], opd[lead]);
        n1    = next_acc(model_acc[lead+1], op[lead], opd[lead]);
        r0    = n0;
        r0[0] = n0[0] ^ f[lead];
        r1    = n1;
        r1[0] = n1[0] ^ f[lead+1];
        if (r0 == r1) begin
          ev[lead]         = 1'b1;
          ed[lead]         = r0;
          eh[lead]         = cur_base + hart_id_t'(lead);
          model_acc[lead]   = n0;
          model_acc[lead+1] = n1;
          model_ckpt[p]     = r0;
        end else begin
          ee[p]             = 1'b1;  // Drop, pulse and roll back
          model_acc[lead]   = model_ckpt[p];
          model_acc[lead+1] = model_ckpt[p];
          pair_hold[p]      = HoldCycles;
        end
      end
    end
    run_cycle(v, op, opd, f, ev, ed, eh, ee);
  endtask

  // Drain the pipeline before and after the new mode takes effect
  task automatic switch_mode(input hmr_mode_e m);
    idle_cycles(Latency + HoldCycles);
    cur_mode = m;
    cur_base = hart_id_t'($urandom_range(0, 255));
    idle_cycles(2);
  endtask

  initial begin
    rst_n        <= 1'b0;
    dmr_mode     <= 1'b0;
    hart_base    <= '0;
    lane_valid   <= '0;
    lane_operand <= '0;
    lane_fault   <= '0;
    for (int unsigned i = 0; i < NumCores; i++) begin
      lane_opcode[i] <= OP_LOAD;
      model_acc[i]   = '0;
    end
    for (int unsigned p = 0; p < NumPairs; p++) begin
      model_ckpt[p] = '0;
      pair_hold[p]  = 0;
    end
    void'($urandom(Seed));
    cur_mode = MODE_INDEP;
    cur_base = hart_id_t'($urandom_range(0, 255));

    repeat (ResetCycles) @(posedge clk);
    rst_n <= 1'b1;
    repeat (Latency) push_expect('0, '0, '0, '0);  // Outputs stay quiet out of reset

    repeat (OpsPerPhase) issue_indep(1'b0);
    repeat (OpsPerPhase) issue_indep(1'b1);
    switch_mode(MODE_DMR);
    repeat (OpsPerPhase) issue_dmr(1'b0);
    repeat (OpsPerPhase) issue_dmr(1'b1);
    switch_mode(MODE_INDEP);
    repeat (OpsPerPhase) issue_indep(1'b1);
    switch_mode(MODE_DMR);
    repeat (OpsPerPhase) issue_dmr(1'b1);
    idle_cycles(Latency + HoldCycles);

    $display("Checks: %0d, errors: valid %0d, data %0d, hart %0d, dmr_error %0d",
             n_checks, valid_errs, data_errs, hart_errs, pulse_errs);
    if ((valid_errs + data_errs + hart_errs + pulse_errs) == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_hmr_acc_top

`default_nettype wire

// ==== sources.f ====
source/core_pkg.sv
source/hmr_pkg.sv
source/hmr_input_bind.sv
source/acc_core.sv
source/hmr_result_vote.sv
source/hmr_acc_top.sv
verif/tb_hmr_acc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the HMR accumulator testbench with Verilator.
# Exits non-zero if the build or the run fails, or the log reports a failure.

cd "$(dirname "$0")" || exit 1

TOP=tb_hmr_acc_top
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" \
  -Mdir obj_dir -o "$TOP" -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0
